/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = tb_board_bus
FILE_LIST = all.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
soc_map_pkg.sv
soc_bus_pkg.sv
ram_port.sv
io_port.sv
bus_response_mux.sv
board_bus_top.sv
tb_board_bus.sv

/* board_bus_top.sv */
`default_nettype none

module board_bus_top #(
    parameter int ram_words = 1024
) (
    input  wire logic                  CLOCK_50,
    input  wire logic                  KEY0,
    input  wire soc_bus_pkg::bus_req_t bus_req,
    output soc_bus_pkg::bus_resp_t     bus_resp,
    input  wire logic [7:0]            key_ascii,
    input  wire logic                  key_pressed,
    input  wire logic                  irq_ack,
    output logic [3:0]                 irq_vector,
    input  wire logic [7:0]            sd_dout,
    input  wire logic                  sd_byte_available,
    input  wire logic                  sd_ready,
    output logic                       sd_rd_start,
    output logic [31:0]                sd_addr,
    output logic                       uart_strobe,
    output logic [7:0]                 uart_data
);

    soc_bus_pkg::port_result_t ram_result;
    soc_bus_pkg::port_result_t io_result;

    // Block RAM
    ram_port #(
        .ram_words(ram_words)
    ) u_ram_port (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus_req  (bus_req),
        .result   (ram_result)
    );

    // Keyboard, SD and UART registers
    io_port u_io_port (
        .CLOCK_50          (CLOCK_50),
        .KEY0              (KEY0),
        .bus_req           (bus_req),
        .result            (io_result),
        .key_ascii         (key_ascii),
        .key_pressed       (key_pressed),
        .irq_ack           (irq_ack),
        .irq_vector        (irq_vector),
        .sd_dout           (sd_dout),
        .sd_byte_available (sd_byte_available),
        .sd_ready          (sd_ready),
        .sd_rd_start       (sd_rd_start),
        .sd_addr           (sd_addr),
        .uart_strobe       (uart_strobe),
        .uart_data         (uart_data)
    );

    bus_response_mux u_bus_response_mux (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .read_enable (bus_req.read_enable),
        .ram_result  (ram_result),
        .io_result   (io_result),
        .bus_resp    (bus_resp)
    );

endmodule

`default_nettype wire

/* bus_response_mux.sv */
`default_nettype none

module bus_response_mux (
    input  wire logic                      CLOCK_50,
    input  wire logic                      KEY0,
    input  wire logic                      read_enable,
    input  wire soc_bus_pkg::port_result_t ram_result,
    input  wire soc_bus_pkg::port_result_t io_result,
    output soc_bus_pkg::bus_resp_t         bus_resp
);

    logic        any_valid;
    logic        capture;
    logic        read_done_q;
    logic [63:0] read_data_q;

    assign any_valid = ram_result.valid || io_result.valid;

    // First valid cycle of a read loads the response
    assign capture = read_enable && !read_done_q && any_valid;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_done_q <= 1'b0;
        end else if (!read_enable) begin
            read_done_q <= 1'b0;
        end else if (capture) begin
            read_done_q <= 1'b1;
        end
    end

    // Data stays put until the next read captures
    always_ff @(posedge CLOCK_50) begin
        if (capture) begin
            read_data_q <= ram_result.valid ? ram_result.data : io_result.data;
        end
    end

    assign bus_resp = '{read_data: read_data_q, read_done: read_done_q};

    // Address maps of the two ports must not overlap
    a_one_port: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        !(ram_result.valid && io_result.valid)
    ) else $error("bus_response_mux: RAM and I/O both answered a read");

endmodule

`default_nettype wire

/* bus_stimulus.txt */
# cmd a b c in hex: W addr data rd_pulses | R addr type expected | K ascii irq 0
# A 0 irq 0 | S bytes 0 0 | C cache_index 0 0 | U addr data uart_strobes
W 1000 8badf00d 0
W 1004 7f01a2c3 0
R 1000 2 ffffffff8badf00d
R 1000 6 000000008badf00d
R 1000 0 000000000000000d
R 1001 0 fffffffffffffff0
R 1002 0 ffffffffffffffad
R 1003 0 ffffffffffffff8b
R 1001 4 00000000000000f0
R 1003 4 000000000000008b
R 1000 1 fffffffffffff00d
R 1002 5 0000000000008bad
R 1004 1 ffffffffffffa2c3
R 1000 3 7f01a2c38badf00d
K 41 1 0
R 100 0 41
A 0 0 0
K 0 0 0
W 110 0000abcd 0
W 118 1 1
U 108 1234565a 1
U 120 77 0
R 120 0 1
S 200 0 0
R 128 0 1
C 0 0 0
C 1ff 0 0
C 9a 0 0
S 1 0 0
R 128 0 0

/* io_port.sv */
`default_nettype none

module io_port (
    input  wire logic                  CLOCK_50,
    input  wire logic                  KEY0,
    input  wire soc_bus_pkg::bus_req_t bus_req,
    output soc_bus_pkg::port_result_t  result,
    input  wire logic [7:0]            key_ascii,
    input  wire logic                  key_pressed,
    input  wire logic                  irq_ack,
    output logic [3:0]                 irq_vector,
    input  wire logic [7:0]            sd_dout,
    input  wire logic                  sd_byte_available,
    input  wire logic                  sd_ready,
    output logic                       sd_rd_start,
    output logic [31:0]                sd_addr,
    output logic                       uart_strobe,
    output logic [7:0]                 uart_data
);

    localparam int cache_aw = $clog2(soc_map_pkg::sector_bytes);
    localparam logic [63:0] cache_limit =
        soc_map_pkg::sdc_cache_base + 64'(soc_map_pkg::sector_bytes);

    // One sector of SD data
    logic [7:0] sd_cache [0:soc_map_pkg::sector_bytes-1];

    logic                key_sel;
    logic                uart_sel;
    logic                sdc_addr_sel;
    logic                sdc_read_sel;
    logic                sdc_ready_sel;
    logic                sdc_avail_sel;
    logic                cache_sel;
    logic                read_sel;
    logic [63:0]         cache_offset;
    logic [cache_aw-1:0] cache_idx;
    logic                valid_q;
    logic [63:0]         data_q;
    logic                sd_byte_d;
    logic                byte_edge;
    logic [cache_aw-1:0] byte_index;
    logic                sd_cache_avail;
    logic                uart_trig;
    logic                uart_trig_d;

    // Register decode
    assign key_sel = (bus_req.address == soc_map_pkg::key_addr);
    assign uart_sel = (bus_req.address == soc_map_pkg::uart_addr);
    assign sdc_addr_sel = (bus_req.address == soc_map_pkg::sdc_addr_reg);
    assign sdc_read_sel = (bus_req.address == soc_map_pkg::sdc_read_reg);
    assign sdc_ready_sel = (bus_req.address == soc_map_pkg::sdc_ready_reg);
    assign sdc_avail_sel = (bus_req.address == soc_map_pkg::sdc_avail_reg);
    assign cache_sel = (bus_req.address >= soc_map_pkg::sdc_cache_base) &&
                       (bus_req.address < cache_limit);

    assign cache_offset = bus_req.address - soc_map_pkg::sdc_cache_base;
    assign cache_idx = cache_offset[cache_aw-1:0];

    // Only these addresses answer a read
    assign read_sel = bus_req.read_enable &&
                      (key_sel || sdc_ready_sel || sdc_avail_sel || cache_sel);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= read_sel;
        end
    end

    // Read value, one cycle after the request
    always_ff @(posedge CLOCK_50) begin
        if (read_sel && !valid_q) begin
            if (key_sel) begin
                data_q <= {56'd0, key_ascii};
            end else if (sdc_ready_sel) begin
                data_q <= {63'd0, sd_ready};
            end else if (sdc_avail_sel) begin
                data_q <= {63'd0, sd_cache_avail};
            end else begin
                data_q <= {56'd0, sd_cache[cache_idx]};
            end
        end
    end

    assign result.valid = valid_q && bus_req.read_enable;
    assign result.data = data_q;

    // SD byte strobe, rising edge only
    assign byte_edge = sd_byte_available && !sd_byte_d;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sd_byte_d <= 1'b0;
            byte_index <= '0;
            sd_cache_avail <= 1'b0;
        end else begin
            sd_byte_d <= sd_byte_available;
            if (byte_edge) begin
                byte_index <= byte_index + cache_aw'(1);
                if (byte_index == cache_aw'(soc_map_pkg::sector_bytes - 1)) begin
                    sd_cache_avail <= 1'b1;
                end else if (byte_index == '0) begin
                    // New sector started
                    sd_cache_avail <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (byte_edge) begin
            sd_cache[byte_index] <= sd_dout;
        end
    end

    // Sector address and read start
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sd_addr <= 32'd0;
            sd_rd_start <= 1'b0;
        end else begin
            sd_rd_start <= bus_req.write_enable && sdc_read_sel;
            if (bus_req.write_enable && sdc_addr_sel) begin
                sd_addr <= bus_req.write_data[31:0];
            end
        end
    end

    // UART strobe fires once per store, even if the store is held
    assign uart_trig = bus_req.write_enable && uart_sel;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            uart_trig_d <= 1'b0;
        end else begin
            uart_trig_d <= uart_trig;
        end
    end

    assign uart_strobe = uart_trig && !uart_trig_d;
    assign uart_data = bus_req.write_data[7:0];

    // Keyboard interrupt latch; ack has priority over a new press
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_vector <= 4'd0;
        end else if (irq_ack && (irq_vector != 4'd0)) begin
            irq_vector <= 4'd0;
        end else if (key_pressed && (key_ascii != 8'd0)) begin
            irq_vector <= 4'd1;
        end
    end

    // SD controller expects a single-cycle start
    a_rd_start_pulse: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        sd_rd_start |=> !sd_rd_start
    ) else $error("io_port: sd_rd_start held for two cycles");

endmodule

`default_nettype wire

/* ram_port.sv */
`default_nettype none

module ram_port #(
    parameter int ram_words = 1024
) (
    input  wire logic                      CLOCK_50,
    input  wire logic                      KEY0,
    input  wire soc_bus_pkg::bus_req_t     bus_req,
    output soc_bus_pkg::port_result_t      result
);

    localparam int idx_w = $clog2(ram_words);
    localparam logic [63:0] ram_limit = soc_map_pkg::ram_base + 64'(ram_words) * 4;

    // Word array, mapped into block RAM
    logic [31:0] mem [0:ram_words-1];

    logic [63:0]            ram_offset;
    logic [idx_w-1:0]       word_idx;
    logic [idx_w-1:0]       rd_idx;
    logic                   ram_sel;
    logic                   read_sel;
    logic                   load_step;
    logic                   is_ld;
    logic                   beat_q;
    logic                   valid_q;
    soc_bus_pkg::load_word_u load_q;
    logic [31:0]            shifted;

    assign ram_sel = (bus_req.address >= soc_map_pkg::ram_base) &&
                     (bus_req.address < ram_limit);
    assign ram_offset = bus_req.address - soc_map_pkg::ram_base;
    assign word_idx = ram_offset[idx_w+1:2];

    assign read_sel = bus_req.read_enable && ram_sel;
    assign is_ld = (bus_req.read_type == soc_bus_pkg::load_ld);

    // A read step is taken every cycle until the result is complete
    assign load_step = read_sel && !valid_q;

    // Second beat of ld fetches the following word
    assign rd_idx = word_idx + idx_w'(beat_q);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat_q <= 1'b0;
            valid_q <= 1'b0;
        end else if (!read_sel) begin
            beat_q <= 1'b0;
            valid_q <= 1'b0;
        end else if (load_step) begin
            if (is_ld && !beat_q) begin
                beat_q <= 1'b1;
            end else begin
                valid_q <= 1'b1;
            end
        end
    end

    // Registered read port, and word stores
    always_ff @(posedge CLOCK_50) begin
        if (load_step) begin
            if (beat_q) begin
                load_q.half[1] <= mem[rd_idx];
            end else begin
                load_q.half[0] <= mem[rd_idx];
            end
        end
        if (bus_req.write_enable && ram_sel) begin
            mem[word_idx] <= bus_req.write_data[31:0];
        end
    end

    // Byte lane selection for sub-word loads
    assign shifted = load_q.half[0] >> {bus_req.address[1:0], 3'b000};

    always_comb begin
        result.valid = valid_q && bus_req.read_enable;
        case (bus_req.read_type)
            soc_bus_pkg::load_lb: begin
                result.data = {{56{shifted[7]}}, shifted[7:0]};
            end
            soc_bus_pkg::load_lh: begin
                result.data = {{48{shifted[15]}}, shifted[15:0]};
            end
            soc_bus_pkg::load_lw: begin
                result.data = {{32{load_q.half[0][31]}}, load_q.half[0]};
            end
            soc_bus_pkg::load_ld: begin
                result.data = load_q.dword;
            end
            soc_bus_pkg::load_lbu: begin
                result.data = {56'd0, shifted[7:0]};
            end
            soc_bus_pkg::load_lhu: begin
                result.data = {48'd0, shifted[15:0]};
            end
            soc_bus_pkg::load_lwu: begin
                result.data = {32'd0, load_q.half[0]};
            end
            default: begin
                result.data = '0;
            end
        endcase
    end

    // The two beats of ld must stay inside one aligned doubleword
    a_ld_aligned: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        (read_sel && is_ld) |-> (bus_req.address[2:0] == 3'b000)
    ) else $error("ram_port: ld to unaligned address %h", bus_req.address);

endmodule

`default_nettype wire

/* soc_bus_pkg.sv */
`default_nettype none

// Types carried on the CPU load/store bus
package soc_bus_pkg;

    // Load kinds, encoded like funct3 of the RISC-V loads
    typedef enum logic [2:0] {
        load_lb  = 3'b000,
        load_lh  = 3'b001,
        load_lw  = 3'b010,
        load_ld  = 3'b011,
        load_lbu = 3'b100,
        load_lhu = 3'b101,
        load_lwu = 3'b110
    } load_type_e;

    // One bus cycle as the CPU drives it
    typedef struct packed {
        logic [63:0] address;
        logic [63:0] write_data;
        logic        write_enable;
        logic        read_enable;
        load_type_e  read_type;
    } bus_req_t;

    // Read response back to the CPU
    typedef struct packed {
        logic [63:0] read_data;
        logic        read_done;
    } bus_resp_t;

    // What one port has for the read in progress
    typedef struct packed {
        logic        valid;
        logic [63:0] data;
    } port_result_t;

    // Load word, seen whole or as the two words of a doubleword load
    typedef union packed {
        logic [63:0]      dword;
        logic [1:0][31:0] half;
    } load_word_u;

endpackage

`default_nettype wire

/* soc_map_pkg.sv */
`default_nettype none

// Address map of the board bus
package soc_map_pkg;

    // Start of block RAM; its size comes from the ram_words parameter
    localparam logic [63:0] ram_base = 64'h0000_0000_0000_1000;

    // Keyboard ASCII register, read only
    localparam logic [63:0] key_addr = 64'h0000_0000_0000_0100;

    // UART data register, write only
    localparam logic [63:0] uart_addr = 64'h0000_0000_0000_0108;

    // SD controller registers
    localparam logic [63:0] sdc_addr_reg = 64'h0000_0000_0000_0110;
    localparam logic [63:0] sdc_read_reg = 64'h0000_0000_0000_0118;
    localparam logic [63:0] sdc_ready_reg = 64'h0000_0000_0000_0120;

    // Set once a whole sector sits in the cache
    localparam logic [63:0] sdc_avail_reg = 64'h0000_0000_0000_0128;

    // Byte window onto the sector cache
    localparam logic [63:0] sdc_cache_base = 64'h0000_0000_0000_0200;

    // One SD sector
    localparam int sector_bytes = 512;

endpackage

`default_nettype wire

/* tb_board_bus.sv */
`default_nettype none

module tb_board_bus;

    localparam int read_timeout = 16;

    logic                  CLOCK_50 = 1'b0;
    logic                  KEY0;
    soc_bus_pkg::bus_req_t bus_req;
    soc_bus_pkg::bus_resp_t bus_resp;
    logic [7:0]            key_ascii;
    logic                  key_pressed;
    logic                  irq_ack;
    logic [3:0]            irq_vector;
    logic [7:0]            sd_dout;
    logic                  sd_byte_available;
    logic                  sd_ready;
    logic                  sd_rd_start;
    logic [31:0]           sd_addr;
    logic                  uart_strobe;
    logic [7:0]            uart_data;

    int          errors = 0;
    int          timeouts = 0;
    int          rd_pulses = 0;
    int          uart_pulses = 0;
    logic [7:0]  uart_last = 8'd0;
    logic [31:0] lfsr = 32'h1acbe975;
    logic [8:0]  cache_pos = 9'd0;
    // Bytes fed to the SD cache, kept for cache reads
    logic [7:0]  sector_data [0:soc_map_pkg::sector_bytes-1];

    board_bus_top u_dut (
        .CLOCK_50          (CLOCK_50),
        .KEY0              (KEY0),
        .bus_req           (bus_req),
        .bus_resp          (bus_resp),
        .key_ascii         (key_ascii),
        .key_pressed       (key_pressed),
        .irq_ack           (irq_ack),
        .irq_vector        (irq_vector),
        .sd_dout           (sd_dout),
        .sd_byte_available (sd_byte_available),
        .sd_ready          (sd_ready),
        .sd_rd_start       (sd_rd_start),
        .sd_addr           (sd_addr),
        .uart_strobe       (uart_strobe),
        .uart_data         (uart_data)
    );

    always #10 CLOCK_50 = ~CLOCK_50;

    // Pulse counters for the SD start and UART strobes
    always @(negedge CLOCK_50) begin
        if (sd_rd_start) begin
            rd_pulses = rd_pulses + 1;
        end
        if (uart_strobe) begin
            uart_pulses = uart_pulses + 1;
            uart_last = uart_data;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        errors++;
    endtask

    task automatic run_load(input string name, input logic [63:0] addr,
                            input logic [2:0] kind, input logic [63:0] expected);
        int latency;
        int want;
        logic [63:0] first_data;
        // ld takes one more beat than the single-word loads
        want = (kind == 3'b011) ? 3 : 2;
        @(posedge CLOCK_50);
        bus_req.address <= addr;
        bus_req.read_type <= soc_bus_pkg::load_type_e'(kind);
        bus_req.read_enable <= 1'b1;
        latency = 0;
        @(negedge CLOCK_50);
        while (!bus_resp.read_done && latency < read_timeout) begin
            @(negedge CLOCK_50);
            latency++;
        end
        if (!bus_resp.read_done) begin
            $display("timeout: no read_done for %s", name);
            timeouts++;
        end else begin
            first_data = bus_resp.read_data;
            if (latency != want) begin
                report_mismatch({name, " latency"}, 64'(want), 64'(latency));
            end
            if (first_data !== expected) begin
                report_mismatch(name, expected, first_data);
            end
            // Response holds while read_enable stays high
            repeat (2) @(negedge CLOCK_50);
            if (bus_resp.read_done !== 1'b1) begin
                report_mismatch({name, " done hold"}, 64'd1, {63'd0, bus_resp.read_done});
            end
            if (bus_resp.read_data !== expected) begin
                report_mismatch({name, " data hold"}, expected, bus_resp.read_data);
            end
        end
        @(posedge CLOCK_50);
        bus_req.read_enable <= 1'b0;
        @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        if (bus_resp.read_done !== 1'b0) begin
            report_mismatch({name, " done clear"}, 64'd0, {63'd0, bus_resp.read_done});
        end
    endtask

    task automatic run_store(input logic [63:0] addr, input logic [63:0] data,
                             input int hold);
        @(posedge CLOCK_50);
        bus_req.address <= addr;
        bus_req.write_data <= data;
        bus_req.write_enable <= 1'b1;
        repeat (hold) @(posedge CLOCK_50);
        bus_req.write_enable <= 1'b0;
        repeat (3) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
    endtask

    task automatic press_key(input string name, input logic [7:0] ascii,
                             input logic [3:0] irq_expected);
        @(posedge CLOCK_50);
        key_ascii <= ascii;
        key_pressed <= 1'b1;
        @(posedge CLOCK_50);
        key_pressed <= 1'b0;
        @(negedge CLOCK_50);
        if (irq_vector !== irq_expected) begin
            report_mismatch(name, {60'd0, irq_expected}, {60'd0, irq_vector});
        end
    endtask

    task automatic ack_irq(input string name, input logic [3:0] irq_expected);
        @(posedge CLOCK_50);
        irq_ack <= 1'b1;
        @(posedge CLOCK_50);
        irq_ack <= 1'b0;
        @(negedge CLOCK_50);
        if (irq_vector !== irq_expected) begin
            report_mismatch(name, {60'd0, irq_expected}, {60'd0, irq_vector});
        end
    endtask

    // SD controller busy while it streams bytes
    task automatic feed_bytes(input int count);
        logic [7:0] value;
        value = 8'd0;
        @(posedge CLOCK_50);
        sd_ready <= 1'b0;
        for (int i = 0; i < count; i++) begin
            for (int k = 0; k < 8; k++) begin
                value = {lfsr[0], value[7:1]};
                lfsr = lfsr_step(lfsr);
            end
            sector_data[cache_pos] = value;
            cache_pos = cache_pos + 9'd1;
            @(posedge CLOCK_50);
            sd_dout <= value;
            sd_byte_available <= 1'b1;
            @(posedge CLOCK_50);
            sd_byte_available <= 1'b0;
        end
        @(posedge CLOCK_50);
        sd_ready <= 1'b1;
    endtask

    initial begin
        int fd;
        int n;
        int line_no;
        int start;
        string line;
        string name;
        logic [7:0] cmd;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        KEY0 = 1'b0;
        bus_req = '0;
        key_ascii = 8'd0;
        key_pressed = 1'b0;
        irq_ack = 1'b0;
        sd_dout = 8'd0;
        sd_byte_available = 1'b0;
        sd_ready = 1'b0;
        line_no = 0;
        repeat (2) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        sd_ready <= 1'b1;
        @(negedge CLOCK_50);
        if (bus_resp.read_done !== 1'b0) begin
            report_mismatch("reset read_done", 64'd0, {63'd0, bus_resp.read_done});
        end
        fd = $fopen("bus_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open bus_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd) && timeouts == 0) begin
                n = $fgets(line, fd);
                line_no++;
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %h %h", cmd, a, b, c);
                    name = $sformatf("%c line %0d", cmd, line_no);
                    case (cmd)
                        "W": begin
                            start = rd_pulses;
                            run_store(a, b, 1);
                            if (64'(rd_pulses - start) != c) begin
                                report_mismatch({name, " sd_rd_start"}, c,
                                                64'(rd_pulses - start));
                            end
                            if (a == soc_map_pkg::sdc_addr_reg && sd_addr !== b[31:0]) begin
                                report_mismatch({name, " sd_addr"}, b, {32'd0, sd_addr});
                            end
                        end
                        "R": run_load(name, a, b[2:0], c);
                        "K": press_key(name, a[7:0], b[3:0]);
                        "A": ack_irq(name, b[3:0]);
                        "S": feed_bytes(int'(a));
                        "C": begin
                            run_load(name, soc_map_pkg::sdc_cache_base + a, 3'b000,
                                     {56'd0, sector_data[a[8:0]]});
                        end
                        "U": begin
                            // Held for two cycles, still one strobe
                            start = uart_pulses;
                            run_store(a, b, 2);
                            if (64'(uart_pulses - start) != c) begin
                                report_mismatch({name, " strobes"}, c,
                                                64'(uart_pulses - start));
                            end
                            if (c != 64'd0 && uart_last !== b[7:0]) begin
                                report_mismatch({name, " uart_data"}, {56'd0, b[7:0]},
                                                {56'd0, uart_last});
                            end
                        end
                        default: begin
                            $display("unknown command on stimulus line %0d", line_no);
                            errors++;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
